// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rpDrive_tb
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+include
hdl/rpRegPkg.sv
hdl/rpCmdPkg.sv
hdl/rpAxiRegs.sv
hdl/rpCmdFifo.sv
hdl/rpDriveExec.sv
hdl/rpDrive.sv
test/rpDrive_properties.sv
test/rpDrive_tb.sv

// File: hdl/rpAxiRegs.sv
// Drive register block with AXI4-Lite slave
`default_nettype none

`include "rp_params.svh"

module rpAxiRegs
   import rpRegPkg::*;
   import rpCmdPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // Write address and data
   input  logic        awvalid,
   output logic        awready,
   input  logic [4:0]  awaddr,
   input  logic        wvalid,
   output logic        wready,
   input  logic [31:0] wdata,
   // Write response
   output logic        bvalid,
   input  logic        bready,
   output logic [1:0]  bresp,
   // Read address and data
   input  logic        arvalid,
   output logic        arready,
   input  logic [4:0]  araddr,
   output logic        rvalid,
   input  logic        rready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   // Command queue side
   output logic        push,
   output rpCmdT       pushCmd,
   input  logic        full,
   // Executor side
   input  rpDoneT      done,
   input  logic [9:0]  cyl,
   input  logic [15:0] cnt
);

   // Room for a full FIFO plus the command in the executor
   localparam int PW = $clog2(`RP_FIFO_DEPTH) + 2;

   logic          wrEn;
   logic          rdEn;
   rpWordU        wrWord;
   logic          goCmd;
   logic          codeOk;
   logic [4:0]    fun;
   logic [9:0]    dcCyl;
   logic          err;
   logic [PW-1:0] pending;
   rpWordU        cs1Word;
   rpWordU        dcWord;
   rpStatusT      status;
   logic [31:0]   rdNext;
   logic [1:0]    rrespNext;

   //////////////////////////////////////////////////////////////////////
   // Handshakes
   //////////////////////////////////////////////////////////////////////

   // Address and data taken together, one response at a time
   assign awready = ~bvalid;
   assign wready  = ~bvalid;
   assign wrEn    = awvalid & wvalid & ~bvalid;
   assign bresp   = 2'b00;

   assign arready = ~rvalid;
   assign rdEn    = arvalid & ~rvalid;

   //////////////////////////////////////////////////////////////////////
   // Write decode and command issue
   //////////////////////////////////////////////////////////////////////

   // Low half of the write word, no byte strobes
   assign wrWord = wdata[15:0];
   assign goCmd  = wrEn & (awaddr == `RP_CS1_ADDR) & wrWord.cs1.go;

   // Functions that go through the queue
   always_comb
   begin
      case (wrWord.cs1.fun)
         `RP_FUN_NOP, `RP_FUN_SEEK, `RP_FUN_RECAL: codeOk = 1'b1;
         default: codeOk = 1'b0;
      endcase
   end

   // Dropped when the queue is full
   assign push    = goCmd & codeOk & ~full;
   assign pushCmd = '{fun: wrWord.cs1.fun, cyl: dcCyl};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bvalid  <= 1'b0;
         rvalid  <= 1'b0;
         fun     <= '0;
         dcCyl   <= '0;
         err     <= 1'b0;
         pending <= '0;
      end
      else
      begin
         // Response held until the host takes it
         if (wrEn)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;

         if (rdEn)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;

         // Function kept whether or not go is set
         if (wrEn && awaddr == `RP_CS1_ADDR)
            fun <= wrWord.cs1.fun;

         if (wrEn && awaddr == `RP_DC_ADDR)
            dcCyl <= wrWord.dc.cyl;

         // Sticky error, cleared only by drive clear
         if (goCmd)
         begin
            if (wrWord.cs1.fun == `RP_FUN_DCLR)
               err <= 1'b0;
            else if (!codeOk || full)
               err <= 1'b1;
         end

         // Commands issued but not yet completed
         pending <= pending + PW'(push) - PW'(done.valid);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////

   // Go stays up while work is outstanding
   always_comb
   begin
      cs1Word.cs1 = '{rsvd0: '0, dva: 1'b1, rsvd1: '0, fun: fun, go: pending != '0};
      dcWord.dc   = '{rsvd: '0, cyl: dcCyl};
      status      = '{err: err, drdy: pending == '0, full: full, rsvd: '0};
   end

   always_comb
   begin
      rdNext    = '0;
      rrespNext = 2'b00;
      case (araddr)
         `RP_CS1_ADDR: rdNext = {16'h0, cs1Word};
         `RP_DC_ADDR:  rdNext = {16'h0, dcWord};
         `RP_DS_ADDR:  rdNext = {16'h0, status};
         `RP_CC_ADDR:  rdNext = {16'h0, cnt};
         `RP_CYL_ADDR: rdNext = {22'h0, cyl};
         // Unmapped offset
         default:      rrespNext = 2'b10;
      endcase
   end

   // Read payload captured with the address
   always_ff @(posedge clk)
   begin
      if (rdEn)
      begin
         rdata <= rdNext;
         rresp <= rrespNext;
      end
   end

endmodule

`default_nettype wire

// File: hdl/rpCmdFifo.sv
// Drive command FIFO
`default_nettype none

module rpCmdFifo
   import rpCmdPkg::*;
#(
   parameter int DEPTH = 4
)
(
   input  logic  clk,
   input  logic  rst,
   // Register block side
   input  logic  push,
   input  rpCmdT pushCmd,
   output logic  full,
   // Executor side
   output logic  valid,
   output rpCmdT popCmd,
   input  logic  pop
);

   localparam int AW = $clog2(DEPTH);

   rpCmdT         mem [DEPTH];
   logic [AW-1:0] wrPtr;
   logic [AW-1:0] rdPtr;
   logic [AW:0]   occ;

   //////////////////////////////////////////////////////////////////////
   // Status and head
   //////////////////////////////////////////////////////////////////////

   assign full   = occ == (AW + 1)'(DEPTH);
   assign valid  = occ != '0;
   assign popCmd = mem[rdPtr];

   //////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   //////////////////////////////////////////////////////////////////////

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         occ   <= '0;
      end
      else
      begin
         if (push)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         occ <= occ + (AW + 1)'(push) - (AW + 1)'(pop);
      end
   end

   // Slot storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wrPtr] <= pushCmd;
   end

endmodule

`default_nettype wire

// File: hdl/rpCmdPkg.sv
// Drive command and completion types
`default_nettype none

package rpCmdPkg;

   //////////////////////////////////////////////////////////////////////
   // Queued command
   //////////////////////////////////////////////////////////////////////

   // Function code and target cylinder
   typedef struct packed {
      logic [4:0] fun;
      logic [9:0] cyl;
   } rpCmdT;

   //////////////////////////////////////////////////////////////////////
   // Completion pulse
   //////////////////////////////////////////////////////////////////////

   // Single-cycle strobe from the executor
   typedef struct packed {
      logic       valid;
      logic [4:0] fun;
   } rpDoneT;

endpackage

`default_nettype wire

// File: hdl/rpDrive.sv
// Disk drive register subsystem top
`default_nettype none

`include "rp_params.svh"

module rpDrive
   import rpCmdPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        awvalid,
   output logic        awready,
   input  logic [4:0]  awaddr,
   input  logic        wvalid,
   output logic        wready,
   input  logic [31:0] wdata,
   output logic        bvalid,
   input  logic        bready,
   output logic [1:0]  bresp,
   input  logic        arvalid,
   output logic        arready,
   input  logic [4:0]  araddr,
   output logic        rvalid,
   input  logic        rready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp
);

   // Register block to FIFO
   logic        push;
   rpCmdT       pushCmd;
   logic        full;
   // FIFO to executor
   logic        valid;
   rpCmdT       popCmd;
   logic        pop;
   // Executor back to the registers
   rpDoneT      done;
   logic [9:0]  cylinder;
   logic [15:0] count;

   //////////////////////////////////////////////////////////////////////
   // Register block, queue, executor
   //////////////////////////////////////////////////////////////////////

   rpAxiRegs i_regs (
      .clk     (clk),
      .rst     (rst),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .push    (push),
      .pushCmd (pushCmd),
      .full    (full),
      .done    (done),
      .cyl     (cylinder),
      .cnt     (count)
   );

   rpCmdFifo #(
      .DEPTH (`RP_FIFO_DEPTH)
   ) i_fifo (
      .clk     (clk),
      .rst     (rst),
      .push    (push),
      .pushCmd (pushCmd),
      .full    (full),
      .valid   (valid),
      .popCmd  (popCmd),
      .pop     (pop)
   );

   rpDriveExec i_exec (
      .clk      (clk),
      .rst      (rst),
      .valid    (valid),
      .popCmd   (popCmd),
      .pop      (pop),
      .done     (done),
      .cylinder (cylinder),
      .count    (count)
   );

endmodule

`default_nettype wire

// File: hdl/rpDriveExec.sv
// Drive command executor
`default_nettype none

`include "rp_params.svh"

module rpDriveExec
   import rpCmdPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // FIFO side
   input  logic        valid,
   input  rpCmdT       popCmd,
   output logic        pop,
   // Completion and drive state
   output rpDoneT      done,
   output logic [9:0]  cylinder,
   output logic [15:0] count
);

   localparam int TW = $clog2(`RP_SEEK_CYCLES) + 1;

   typedef enum logic {
      IDLE,
      BUSY
   } stateT;

   stateT         state;
   rpCmdT         cur;
   logic [TW-1:0] timer;
   logic          finish;

   //////////////////////////////////////////////////////////////////////
   // Pop and completion strobes
   //////////////////////////////////////////////////////////////////////

   // Head taken as soon as the drive is idle
   assign pop    = (state == IDLE) & valid;

   // Last cycle of the command
   assign finish = (state == BUSY) & (timer == '0);
   assign done   = '{valid: finish, fun: cur.fun};

   //////////////////////////////////////////////////////////////////////
   // FSM and drive state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= IDLE;
         timer    <= '0;
         cylinder <= '0;
         count    <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (pop)
               begin
                  state <= BUSY;
                  // Seek is slow and everything else takes one cycle
                  if (popCmd.fun == `RP_FUN_SEEK)
                     timer <= TW'(`RP_SEEK_CYCLES - 1);
                  else
                     timer <= '0;
               end
            end
            BUSY:
            begin
               if (finish)
               begin
                  state <= IDLE;
                  count <= count + 16'd1;
                  // NOP keeps the heads where they are
                  if (cur.fun == `RP_FUN_SEEK)
                     cylinder <= cur.cyl;
                  else if (cur.fun == `RP_FUN_RECAL)
                     cylinder <= '0;
               end
               else
                  timer <= timer - 1'b1;
            end
         endcase
      end
   end

   // Command held for the whole busy period
   always_ff @(posedge clk)
   begin
      if (pop)
         cur <= popCmd;
   end

endmodule

`default_nettype wire

// File: hdl/rpRegPkg.sv
// Drive register word layouts
`default_nettype none

package rpRegPkg;

   //////////////////////////////////////////////////////////////////////
   // Control status 1 and desired cylinder views
   //////////////////////////////////////////////////////////////////////

   // CS1 layout, function in bits 5:1, go in bit 0
   typedef struct packed {
      logic [3:0] rsvd0;
      logic       dva;
      logic [4:0] rsvd1;
      logic [4:0] fun;
      logic       go;
   } rpCs1T;

   // DC layout, cylinder in the low ten bits
   typedef struct packed {
      logic [5:0] rsvd;
      logic [9:0] cyl;
   } rpDcT;

   // One 16-bit register word, read as CS1 or as DC
   typedef union packed {
      rpCs1T cs1;
      rpDcT  dc;
   } rpWordU;

   //////////////////////////////////////////////////////////////////////
   // Drive status
   //////////////////////////////////////////////////////////////////////

   // Sticky error, ready, queue full at the top
   typedef struct packed {
      logic        err;
      logic        drdy;
      logic        full;
      logic [12:0] rsvd;
   } rpStatusT;

endpackage

`default_nettype wire

// File: include/rp_params.svh
// Drive register block parameters
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Command queue and executor timing
//////////////////////////////////////////////////////////////////////

// Command slots in the FIFO, power of two
`define RP_FIFO_DEPTH 4

// Executor cycles for a seek
`define RP_SEEK_CYCLES 6

//////////////////////////////////////////////////////////////////////
// Register byte offsets on the host bus
//////////////////////////////////////////////////////////////////////

`define RP_CS1_ADDR 5'h00
`define RP_DC_ADDR  5'h04
`define RP_DS_ADDR  5'h08
`define RP_CC_ADDR  5'h0C
`define RP_CYL_ADDR 5'h10

//////////////////////////////////////////////////////////////////////
// CS1 function codes
//////////////////////////////////////////////////////////////////////

`define RP_FUN_NOP   5'd0
`define RP_FUN_SEEK  5'd2
`define RP_FUN_RECAL 5'd3
`define RP_FUN_DCLR  5'd4

`endif

// File: test/rpDrive_properties.sv
// Drive bus and queue assertions
`default_nettype none

module rpDrive_properties
(
   input logic clk,
   input logic rst,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready,
   input logic push,
   input logic full,
   input logic pop,
   input logic valid
);

   // Responses held until the host takes them
   bHold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   rHold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // Queue never overrun
   noOverflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
      else $error("push into a full command FIFO");

   // Or underrun
   noUnderflow: assert property (@(posedge clk) disable iff (rst) !(pop && !valid))
      else $error("pop from an empty command FIFO");

   // Both responses idle while in reset
   resetIdle: assert property (@(posedge clk) rst |-> !bvalid && !rvalid)
      else $error("response valid during reset");

endmodule

bind rpDrive rpDrive_properties i_props (
   .clk    (clk),
   .rst    (rst),
   .bvalid (bvalid),
   .bready (bready),
   .rvalid (rvalid),
   .rready (rready),
   .push   (push),
   .full   (full),
   .pop    (pop),
   .valid  (valid)
);

`default_nettype wire

// File: test/rpDrive_tb.sv
// Drive register subsystem testbench
`default_nettype none

`include "rp_params.svh"

module rpDrive_tb;

   localparam int TIMEOUT = 200;

   logic        clk;
   logic        rst;
   logic        awvalid;
   logic        awready;
   logic [4:0]  awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [4:0]  araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;

   logic [31:0] randState;
   // Reference model of the drive
   logic [4:0]  expFun;
   logic [9:0]  expDc;
   logic        expErr;
   logic [9:0]  expCyl;
   logic [15:0] expCnt;
   int          modelOcc;
   // Transactions issued and responses seen
   int          wrIssued = 0;
   int          rdIssued = 0;
   int          bSeen = 0;
   int          rSeen = 0;

   rpDrive i_dut (
      .clk     (clk),
      .rst     (rst),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Handshakes completing on this edge
   always @(posedge clk)
   begin
      if (!rst && bvalid && bready)
         bSeen++;
      if (!rst && rvalid && rready)
         rSeen++;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // LCG with halves swapped so the low bits are usable
   function automatic logic [31:0] nextRand();
      randState = randState * 32'd1664525 + 32'd1013904223;
      return {randState[15:0], randState[31:16]};
   endfunction

   // Expected CS1 with data valid in bit 11
   function automatic logic [31:0] cs1Word(input logic [4:0] fun, input logic go);
      return {16'h0, 4'h0, 1'b1, 5'h0, fun, go};
   endfunction

   // Expected DS with error, ready and full in the top bits
   function automatic logic [31:0] dsWord(input logic err, input logic drdy, input logic full);
      return {16'h0, err, drdy, full, 13'h0};
   endfunction

   task automatic abortRun();
      $display("Something failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic timedOut(input string what);
      $display("Timeout while waiting: %s", what);
      abortRun();
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("[ERROR] time %0t: %s = %h, expected %h", $time, name, got, exp);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // AXI4-Lite transactions
   //////////////////////////////////////////////////////////////////////

   task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
      int cycles;
      int stall;
      @(negedge clk);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr;
      wdata   = data;
      cycles  = 0;
      // Taken on the next rising edge once ready is up
      while (!(awready && wready))
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            timedOut("write address and data accepted");
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      wrIssued++;
      cycles  = 0;
      while (!bvalid)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            timedOut("write response");
      end
      checkValue("bresp", {30'h0, bresp}, 32'h0);
      // New writes held off while the response waits
      checkValue("awready", {31'h0, awready}, 32'h0);
      checkValue("wready", {31'h0, wready}, 32'h0);
      // Random hold-off on bready
      stall = int'(nextRand() % 32'd4);
      repeat (stall) @(negedge clk);
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      checkValue("bvalid", {31'h0, bvalid}, 32'h0);
   endtask

   task automatic readReg(input logic [4:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      int cycles;
      int stall;
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = addr;
      cycles  = 0;
      while (!arready)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            timedOut("read address accepted");
      end
      @(negedge clk);
      arvalid = 1'b0;
      rdIssued++;
      cycles  = 0;
      while (!rvalid)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            timedOut("read data");
      end
      // No new read address while data waits
      checkValue("arready", {31'h0, arready}, 32'h0);
      data  = rdata;
      resp  = rresp;
      stall = int'(nextRand() % 32'd4);
      repeat (stall) @(negedge clk);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      checkValue("rvalid", {31'h0, rvalid}, 32'h0);
   endtask

   task automatic readCheck(input logic [4:0] addr, input logic [31:0] exp,
                            input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      readReg(addr, data, resp);
      checkValue({name, " rresp"}, {30'h0, resp}, 32'h0);
      checkValue(name, data, exp);
   endtask

   // Poll DS until ready and drain the model queue
   task automatic waitReady();
      logic [31:0] ds;
      logic [1:0]  resp;
      int          polls;
      polls = 0;
      readReg(`RP_DS_ADDR, ds, resp);
      while (!ds[14])
      begin
         polls++;
         if (polls > TIMEOUT)
            timedOut("drive ready in DS");
         readReg(`RP_DS_ADDR, ds, resp);
      end
      modelOcc = 0;
   endtask

   // One queued function with a fresh DC before a seek
   task automatic issueCmd(input logic [4:0] fun);
      logic [31:0] r;
      r = nextRand();
      if (fun == `RP_FUN_SEEK)
      begin
         writeReg(`RP_DC_ADDR, r);
         expDc  = r[9:0];
         expCyl = r[9:0];
      end
      else if (fun == `RP_FUN_RECAL)
         expCyl = '0;
      // Upper half is junk and ignored by the block
      writeReg(`RP_CS1_ADDR, {r[31:16], 10'h0, fun, 1'b1});
      expFun = fun;
      if (modelOcc >= `RP_FIFO_DEPTH)
         expErr = 1'b1;
      else
      begin
         modelOcc++;
         expCnt++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] val;
      logic [31:0] rd;
      logic [1:0]  resp;
      logic [4:0]  fun;
      int          len;
      rst       = 1'b1;
      awvalid   = 1'b0;
      awaddr    = '0;
      wvalid    = 1'b0;
      wdata     = '0;
      bready    = 1'b0;
      arvalid   = 1'b0;
      araddr    = '0;
      rready    = 1'b0;
      randState = 32'd35216;
      expFun    = '0;
      expDc     = '0;
      expErr    = 1'b0;
      expCyl    = '0;
      expCnt    = '0;
      modelOcc  = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // Reset state
      checkValue("awready", {31'h0, awready}, 32'h1);
      checkValue("wready", {31'h0, wready}, 32'h1);
      checkValue("arready", {31'h0, arready}, 32'h1);
      readCheck(`RP_CS1_ADDR, cs1Word(5'd0, 1'b0), "CS1");
      readCheck(`RP_DS_ADDR, dsWord(1'b0, 1'b1, 1'b0), "DS");
      readCheck(`RP_CC_ADDR, 32'h0, "CC");
      readCheck(`RP_CYL_ADDR, 32'h0, "CYL");
      readCheck(`RP_DC_ADDR, 32'h0, "DC");

      // DC masked to ten bits and function stored without go
      repeat (4)
      begin
         val = nextRand();
         writeReg(`RP_DC_ADDR, val);
         expDc = val[9:0];
         readCheck(`RP_DC_ADDR, {22'h0, expDc}, "DC");
         val    = nextRand();
         expFun = val[4:0];
         writeReg(`RP_CS1_ADDR, {val[31:16], 10'h0, expFun, 1'b0});
         readCheck(`RP_CS1_ADDR, cs1Word(expFun, 1'b0), "CS1");
      end

      // Command bursts no longer than the queue
      repeat (4)
      begin
         val = nextRand();
         len = 1 + int'(val % `RP_FIFO_DEPTH);
         for (int i = 0; i < len; i++)
         begin
            val = nextRand();
            case (val % 32'd3)
               32'd0:   issueCmd(`RP_FUN_NOP);
               32'd1:   issueCmd(`RP_FUN_SEEK);
               default: issueCmd(`RP_FUN_RECAL);
            endcase
         end
         waitReady();
         readCheck(`RP_CC_ADDR, {16'h0, expCnt}, "CC");
         readCheck(`RP_CYL_ADDR, {22'h0, expCyl}, "CYL");
         readCheck(`RP_DS_ADDR, dsWord(expErr, 1'b1, 1'b0), "DS");
         readCheck(`RP_CS1_ADDR, cs1Word(expFun, 1'b0), "CS1");
         readCheck(`RP_DC_ADDR, {22'h0, expDc}, "DC");
      end

      // Bad function code and then drive clear
      val = nextRand();
      fun = 5'd5 + 5'(val % 32'd27);
      if (val[31])
         fun = 5'd1;
      writeReg(`RP_CS1_ADDR, {26'h0, fun, 1'b1});
      expErr = 1'b1;
      expFun = fun;
      readCheck(`RP_DS_ADDR, dsWord(1'b1, 1'b1, 1'b0), "DS");
      readCheck(`RP_CC_ADDR, {16'h0, expCnt}, "CC");
      readCheck(`RP_CS1_ADDR, cs1Word(expFun, 1'b0), "CS1");
      writeReg(`RP_CS1_ADDR, {26'h0, `RP_FUN_DCLR, 1'b1});
      expErr = 1'b0;
      expFun = `RP_FUN_DCLR;
      readCheck(`RP_DS_ADDR, dsWord(1'b0, 1'b1, 1'b0), "DS");
      readCheck(`RP_CS1_ADDR, cs1Word(expFun, 1'b0), "CS1");
      readCheck(`RP_CC_ADDR, {16'h0, expCnt}, "CC");

      // Unmapped read and a write to a read-only register
      val = nextRand();
      readReg(5'h14 + 5'(val % 32'd12), rd, resp);
      checkValue("rresp", {30'h0, resp}, 32'h2);
      checkValue("rdata", rd, 32'h0);
      writeReg(`RP_CC_ADDR, nextRand());
      readCheck(`RP_CC_ADDR, {16'h0, expCnt}, "CC");

      // One response per transaction
      @(negedge clk);
      checkValue("write responses", 32'(bSeen), 32'(wrIssued));
      checkValue("read responses", 32'(rSeen), 32'(rdIssued));
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire
